/* logic/lc3b_pkg.sv */
package lc3b_pkg;

	////////////////////////////////////////////////////////////
	// basic types
	////////////////////////////////////////////////////////////

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;
	// n, z, p from msb down
	typedef logic [2:0]  lc3b_nzp;

	// full LC-3b map, only some of these are executed
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_e;

	typedef enum logic {
		wb_alu,
		wb_mem
	} wb_sel_e;

	////////////////////////////////////////////////////////////
	// control word and stage registers
	////////////////////////////////////////////////////////////

	typedef struct packed {
		lc3b_opcode opcode;
		alu_op_e    aluop;
		logic       imm_sel;
		// 1 selects base + offset6, 0 selects pc + offset9
		logic       addr_sel;
		logic       read_memory;
		logic       write_memory;
		logic       load_regfile;
		logic       load_cc;
		wb_sel_e    wb_sel;
		logic       branch;
	} lc3b_control;

	typedef struct packed {
		logic        valid;
		lc3b_control ctrl;
		lc3b_word    ir;
		lc3b_word    next_instr;
		lc3b_word    sr1;
		lc3b_word    sr2;
		lc3b_reg     dest;
	} de_ex_t;

	typedef struct packed {
		logic        valid;
		lc3b_control ctrl;
		lc3b_word    ir;
		lc3b_word    next_instr;
		lc3b_word    alu_out;
		lc3b_word    address;
		lc3b_word    wdata;
		lc3b_reg     dest;
	} ex_mem_t;

	typedef struct packed {
		ex_mem_t  em;
		lc3b_word rdata;
	} mem_wb_t;

	localparam lc3b_word pc_reset = 16'h0000;
	// registers clear on reset, so start out as zero
	localparam lc3b_nzp  cc_reset = 3'b010;

endpackage : lc3b_pkg

/* logic/lc3b_regfile.sv */
`timescale 1ns/1ps

module lc3b_regfile (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               load,
	input  lc3b_pkg::lc3b_reg  dest,
	input  lc3b_pkg::lc3b_word in,
	input  lc3b_pkg::lc3b_reg  src_a,
	input  lc3b_pkg::lc3b_reg  src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);
	import lc3b_pkg::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// write-through, decode sees the value retiring this cycle
	assign reg_a = (load && dest == src_a) ? in : regs[src_a];
	assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : lc3b_regfile

/* logic/control_rom.sv */
`timescale 1ns/1ps

module control_rom (
	input  lc3b_pkg::lc3b_word    ir,
	output lc3b_pkg::lc3b_control ctrl,
	output lc3b_pkg::lc3b_reg     src1,
	output lc3b_pkg::lc3b_reg     src2,
	output lc3b_pkg::lc3b_reg     dest
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;

	assign opcode = lc3b_opcode'(ir[15:12]);

	// str reads its data register through the second port
	assign src1 = ir[8:6];
	assign src2 = (opcode == op_str) ? ir[11:9] : ir[2:0];
	assign dest = ir[11:9];

	always_comb begin
		ctrl        = '0;
		ctrl.opcode = opcode;
		case (opcode)
			op_add: begin
				ctrl.aluop        = alu_add;
				ctrl.imm_sel      = ir[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end
			op_and: begin
				ctrl.aluop        = alu_and;
				ctrl.imm_sel      = ir[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end
			op_not: begin
				ctrl.aluop        = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end
			// lea leaves the condition codes alone
			op_lea: begin
				ctrl.aluop        = alu_pass;
				ctrl.load_regfile = 1'b1;
			end
			op_ldr: begin
				ctrl.addr_sel     = 1'b1;
				ctrl.read_memory  = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
				ctrl.wb_sel       = wb_mem;
			end
			op_str: begin
				ctrl.addr_sel     = 1'b1;
				ctrl.write_memory = 1'b1;
			end
			// br with no condition bits set is a plain nop
			op_br: begin
				ctrl.branch = |ir[11:9];
			end
			default: begin
				ctrl.aluop = alu_pass;
			end
		endcase
	end

endmodule : control_rom

/* logic/hazard_detection.sv */
`timescale 1ns/1ps

module hazard_detection (
	input  logic                  de_valid,
	input  lc3b_pkg::lc3b_control de_ctrl,
	input  lc3b_pkg::lc3b_reg     src1,
	input  lc3b_pkg::lc3b_reg     src2,
	input  logic                  ex_valid,
	input  lc3b_pkg::lc3b_control ex_ctrl,
	input  lc3b_pkg::lc3b_reg     ex_dest,
	input  logic                  mem_valid,
	input  lc3b_pkg::lc3b_control mem_ctrl,
	input  lc3b_pkg::lc3b_reg     mem_dest,
	input  logic                  wb_valid,
	input  lc3b_pkg::lc3b_control wb_ctrl,
	input  lc3b_pkg::lc3b_reg     wb_dest,
	input  logic                  mem_read_a,
	input  logic                  mem_resp_a,
	input  logic                  mem_busy,
	input  logic                  mem_resp_b,
	output logic                  advance,
	output logic                  stall_de,
	output logic                  fetch_hold
);
	import lc3b_pkg::*;

	logic use1;
	logic use2;
	logic raw1;
	logic raw2;
	logic cc_wait;

	// older stage about to write the given source register
	function automatic logic hits(input logic v, input lc3b_control c,
			input lc3b_reg d, input lc3b_reg s);
		return v && c.load_regfile && d == s;
	endfunction

	// which register ports the decoded instruction really reads
	assign use1 = de_ctrl.opcode inside {op_add, op_and, op_not, op_ldr, op_str};
	assign use2 = ((de_ctrl.opcode inside {op_add, op_and}) && !de_ctrl.imm_sel)
		|| de_ctrl.opcode == op_str;

	assign raw1 = hits(ex_valid, ex_ctrl, ex_dest, src1)
		|| hits(mem_valid, mem_ctrl, mem_dest, src1)
		|| hits(wb_valid, wb_ctrl, wb_dest, src1);
	assign raw2 = hits(ex_valid, ex_ctrl, ex_dest, src2)
		|| hits(mem_valid, mem_ctrl, mem_dest, src2)
		|| hits(wb_valid, wb_ctrl, wb_dest, src2);

	// branch waits until every older cc writer has retired
	assign cc_wait = de_ctrl.branch && ((ex_valid && ex_ctrl.load_cc)
		|| (mem_valid && mem_ctrl.load_cc) || (wb_valid && wb_ctrl.load_cc));

	assign stall_de = de_valid && ((use1 && raw1) || (use2 && raw2) || cc_wait);

	// no fetching from decode of a branch until it leaves write-back
	assign fetch_hold = (de_valid && de_ctrl.branch) || (ex_valid && ex_ctrl.branch)
		|| (mem_valid && mem_ctrl.branch) || (wb_valid && wb_ctrl.branch);

	// every strobe still up must see its response this cycle
	assign advance = (!mem_read_a || mem_resp_a) && (!mem_busy || mem_resp_b);

endmodule : hazard_detection

/* logic/ex_logic.sv */
`timescale 1ns/1ps

module ex_logic (
	input  lc3b_pkg::de_ex_t   ex,
	output lc3b_pkg::lc3b_word alu_out,
	output lc3b_pkg::lc3b_word address
);
	import lc3b_pkg::*;

	lc3b_word imm5;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word operand_b;
	lc3b_word base_addr;
	lc3b_word pc_addr;

	// offsets count words, hence the shift by one
	assign imm5 = {{11{ex.ir[4]}}, ex.ir[4:0]};
	assign off6 = {{9{ex.ir[5]}}, ex.ir[5:0], 1'b0};
	assign off9 = {{6{ex.ir[8]}}, ex.ir[8:0], 1'b0};

	assign operand_b = ex.ctrl.imm_sel ? imm5 : ex.sr2;

	////////////////////////////////////////////////////////////
	// address adders
	////////////////////////////////////////////////////////////

	// ldr/str use base + offset6, lea and br are pc-relative
	assign base_addr = ex.sr1 + off6;
	assign pc_addr   = ex.next_instr + off9;
	assign address   = ex.ctrl.addr_sel ? base_addr : pc_addr;

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	always_comb begin
		alu_out = address;
		case (ex.ctrl.aluop)
			alu_add: begin
				alu_out = ex.sr1 + operand_b;
			end
			alu_and: begin
				alu_out = ex.sr1 & operand_b;
			end
			alu_not: begin
				alu_out = ~ex.sr1;
			end
			// lea result is the effective address itself
			alu_pass: begin
				alu_out = address;
			end
		endcase
	end

endmodule : ex_logic

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               advance,
	input  lc3b_pkg::ex_mem_t  stage,
	input  logic               mem_resp_b,
	input  lc3b_pkg::lc3b_word mem_rdata_b,
	output logic               mem_read_b,
	output logic               mem_write_b,
	output logic [1:0]         mem_wmask_b,
	output lc3b_pkg::lc3b_word mem_address_b,
	output lc3b_pkg::lc3b_word mem_wdata_b,
	output logic               busy,
	output lc3b_pkg::lc3b_word rdata
);
	import lc3b_pkg::*;

	logic     done;
	logic     is_load;
	logic     is_store;
	lc3b_word mdr;

	assign is_load  = stage.valid && stage.ctrl.read_memory;
	assign is_store = stage.valid && stage.ctrl.write_memory;

	// strobe drops once answered, even if the pipe is still stalled
	assign mem_read_b    = is_load && !done;
	assign mem_write_b   = is_store && !done;
	assign mem_wmask_b   = is_store ? 2'b11 : 2'b00;
	assign mem_address_b = stage.address;
	assign mem_wdata_b   = stage.wdata;
	assign busy          = mem_read_b || mem_write_b;

	// late advance takes the captured word
	assign rdata = done ? mdr : mem_rdata_b;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else if (advance) begin
			done <= 1'b0;
		end else if (mem_resp_b) begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_resp_b) begin
			mdr <= mem_rdata_b;
		end
	end

	// control_rom never sets both memory flags
	a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read_b && mem_write_b));

	// request held steady until the memory answers
	a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(busy && !mem_resp_b) |=> busy && $stable(mem_address_b) && $stable(mem_wdata_b));

endmodule : mem_stage

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               mem_resp_a,
	input  lc3b_pkg::lc3b_word mem_rdata_a,
	input  logic               mem_resp_b,
	input  lc3b_pkg::lc3b_word mem_rdata_b,
	output logic               mem_read_a,
	output lc3b_pkg::lc3b_word mem_address_a,
	output logic               mem_read_b,
	output logic               mem_write_b,
	output logic [1:0]         mem_wmask_b,
	output lc3b_pkg::lc3b_word mem_address_b,
	output lc3b_pkg::lc3b_word mem_wdata_b
);
	import lc3b_pkg::*;

	lc3b_word    pc;
	lc3b_word    pc_plus2;
	lc3b_word    fetch_buf;
	lc3b_word    fetch_ir;
	logic        fetch_done;
	logic        consume;
	lc3b_word    de_ir;
	lc3b_word    de_next;
	logic        de_valid;
	logic        issue;
	lc3b_control de_ctrl;
	lc3b_reg     src1;
	lc3b_reg     src2;
	lc3b_reg     de_dest;
	lc3b_word    sr1_val;
	lc3b_word    sr2_val;
	de_ex_t      de_ex;
	ex_mem_t     ex_mem;
	mem_wb_t     mem_wb;
	lc3b_word    ex_alu_out;
	lc3b_word    ex_address;
	lc3b_word    mem_rdata;
	logic        mem_busy;
	logic        advance;
	logic        stall_de;
	logic        fetch_hold;
	lc3b_nzp     cc;
	lc3b_nzp     wb_nzp;
	lc3b_word    wb_data;
	logic        wb_load_reg;
	logic        wb_branch;
	logic        br_taken;

	////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////

	assign pc_plus2      = pc + 16'd2;
	assign mem_address_a = pc;
	assign mem_read_a    = !fetch_hold && !fetch_done;
	assign fetch_ir      = fetch_done ? fetch_buf : mem_rdata_a;
	assign consume       = advance && !stall_de && !fetch_hold;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc         <= pc_reset;
			fetch_done <= 1'b0;
		end else begin
			if (consume) begin
				fetch_done <= 1'b0;
			end else if (mem_resp_a) begin
				fetch_done <= 1'b1;
			end
			// retiring branch owns the pc
			if (advance && wb_branch) begin
				pc <= br_taken ? mem_wb.em.address : mem_wb.em.next_instr;
			end else if (consume) begin
				pc <= pc_plus2;
			end
		end
	end

	// instruction parked here while decode is stalled
	always_ff @(posedge clk) begin
		if (mem_resp_a) begin
			fetch_buf <= mem_rdata_a;
		end
	end

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_valid <= 1'b0;
			de_ir    <= '0;
			de_next  <= pc_reset;
		end else if (advance && !stall_de) begin
			de_valid <= !fetch_hold;
			if (consume) begin
				de_ir   <= fetch_ir;
				de_next <= pc_plus2;
			end
		end
	end

	control_rom control_rom_i (
		.ir   (de_ir),
		.ctrl (de_ctrl),
		.src1 (src1),
		.src2 (src2),
		.dest (de_dest)
	);

	lc3b_regfile lc3b_regfile_i (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (wb_load_reg),
		.dest   (mem_wb.em.dest),
		.in     (wb_data),
		.src_a  (src1),
		.src_b  (src2),
		.reg_a  (sr1_val),
		.reg_b  (sr2_val)
	);

	hazard_detection hazard_detection_i (
		.de_valid   (de_valid),
		.de_ctrl    (de_ctrl),
		.src1       (src1),
		.src2       (src2),
		.ex_valid   (de_ex.valid),
		.ex_ctrl    (de_ex.ctrl),
		.ex_dest    (de_ex.dest),
		.mem_valid  (ex_mem.valid),
		.mem_ctrl   (ex_mem.ctrl),
		.mem_dest   (ex_mem.dest),
		.wb_valid   (mem_wb.em.valid),
		.wb_ctrl    (mem_wb.em.ctrl),
		.wb_dest    (mem_wb.em.dest),
		.mem_read_a (mem_read_a),
		.mem_resp_a (mem_resp_a),
		.mem_busy   (mem_busy),
		.mem_resp_b (mem_resp_b),
		.advance    (advance),
		.stall_de   (stall_de),
		.fetch_hold (fetch_hold)
	);

	assign issue = de_valid && !stall_de;

	////////////////////////////////////////////////////////////
	// execute and memory
	////////////////////////////////////////////////////////////

	ex_logic ex_logic_i (
		.ex      (de_ex),
		.alu_out (ex_alu_out),
		.address (ex_address)
	);

	mem_stage mem_stage_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.advance       (advance),
		.stage         (ex_mem),
		.mem_resp_b    (mem_resp_b),
		.mem_rdata_b   (mem_rdata_b),
		.mem_read_b    (mem_read_b),
		.mem_write_b   (mem_write_b),
		.mem_wmask_b   (mem_wmask_b),
		.mem_address_b (mem_address_b),
		.mem_wdata_b   (mem_wdata_b),
		.busy          (mem_busy),
		.rdata         (mem_rdata)
	);

	// all stage registers move together
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_ex  <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (advance) begin
			de_ex.valid       <= issue;
			de_ex.ctrl        <= issue ? de_ctrl : lc3b_control'('0);
			de_ex.ir          <= de_ir;
			de_ex.next_instr  <= de_next;
			de_ex.sr1         <= sr1_val;
			de_ex.sr2         <= sr2_val;
			de_ex.dest        <= de_dest;
			ex_mem.valid      <= de_ex.valid;
			ex_mem.ctrl       <= de_ex.ctrl;
			ex_mem.ir         <= de_ex.ir;
			ex_mem.next_instr <= de_ex.next_instr;
			ex_mem.alu_out    <= ex_alu_out;
			ex_mem.address    <= ex_address;
			ex_mem.wdata      <= de_ex.sr2;
			ex_mem.dest       <= de_ex.dest;
			mem_wb.em         <= ex_mem;
			mem_wb.rdata      <= mem_rdata;
		end
	end

	////////////////////////////////////////////////////////////
	// write-back
	////////////////////////////////////////////////////////////

	assign wb_data     = (mem_wb.em.ctrl.wb_sel == wb_mem) ? mem_wb.rdata : mem_wb.em.alu_out;
	assign wb_nzp      = {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};
	assign wb_load_reg = advance && mem_wb.em.valid && mem_wb.em.ctrl.load_regfile;
	assign wb_branch   = mem_wb.em.valid && mem_wb.em.ctrl.branch;
	assign br_taken    = |(mem_wb.em.ir[11:9] & cc);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cc <= cc_reset;
		end else if (advance && mem_wb.em.valid && mem_wb.em.ctrl.load_cc) begin
			cc <= wb_nzp;
		end
	end

	// the fetch address only moves with the pipeline
	a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!advance |=> $stable(pc));

	// stalled instruction stays in decode and a bubble goes on
	a_stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		(advance && stall_de) |=> de_valid && $stable(de_ir) && !de_ex.valid);

endmodule : datapath

/* sim/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [1:0]         delay_a,
	input  logic [1:0]         delay_b,
	input  logic               read_a,
	input  lc3b_pkg::lc3b_word address_a,
	output logic               resp_a,
	output lc3b_pkg::lc3b_word rdata_a,
	input  logic               read_b,
	input  logic               write_b,
	input  logic [1:0]         wmask_b,
	input  lc3b_pkg::lc3b_word address_b,
	input  lc3b_pkg::lc3b_word wdata_b,
	output logic               resp_b,
	output lc3b_pkg::lc3b_word rdata_b
);
	import lc3b_pkg::*;

	lc3b_word    imem [256];
	lc3b_word    dmem [256];
	lc3b_word    wr_addr [$];
	lc3b_word    wr_data [$];
	logic [1:0]  wr_mask [$];
	int unsigned moved_a;
	int unsigned moved_b;
	logic [1:0]  cnt_a;
	logic [1:0]  cnt_b;
	logic        wait_a;
	logic        wait_b;
	lc3b_word    held_a;
	lc3b_word    held_b;

	// instruction port, one response pulse per strobe
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_a  <= 1'b0;
			rdata_a <= '0;
			wait_a  <= 1'b0;
			moved_a <= 0;
		end else if (resp_a) begin
			resp_a <= 1'b0;
			wait_a <= 1'b0;
		end else if (read_a) begin
			if (wait_a && address_a != held_a) begin
				moved_a <= moved_a + 1;
			end
			if ((wait_a ? cnt_a : delay_a) == 2'd0) begin
				resp_a  <= 1'b1;
				rdata_a <= imem[address_a[8:1]];
			end else begin
				cnt_a  <= (wait_a ? cnt_a : delay_a) - 2'd1;
				wait_a <= 1'b1;
				held_a <= wait_a ? held_a : address_a;
			end
		end
	end

	// data port, writes are logged in order of response
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_b  <= 1'b0;
			rdata_b <= '0;
			wait_b  <= 1'b0;
			moved_b <= 0;
		end else if (resp_b) begin
			resp_b <= 1'b0;
			wait_b <= 1'b0;
		end else if (read_b || write_b) begin
			if (wait_b && address_b != held_b) begin
				moved_b <= moved_b + 1;
			end
			if ((wait_b ? cnt_b : delay_b) == 2'd0) begin
				resp_b  <= 1'b1;
				rdata_b <= dmem[address_b[8:1]];
				if (write_b) begin
					dmem[address_b[8:1]] <= wdata_b;
					wr_addr.push_back(address_b);
					wr_data.push_back(wdata_b);
					wr_mask.push_back(wmask_b);
				end
			end else begin
				cnt_b  <= (wait_b ? cnt_b : delay_b) - 2'd1;
				wait_b <= 1'b1;
				held_b <= wait_b ? held_b : address_b;
			end
		end
	end

endmodule : tb_memory

/* sim/tb_datapath.sv */
`timescale 1ns/1ps

module tb_datapath;
	import lc3b_pkg::*;

	localparam int n_rand = 120;
	localparam int end_idx = n_rand + 8;
	localparam int timeout_cycles = n_rand * 5 * 4 + 200;

	logic        clk;
	logic        arst_n;
	logic [1:0]  delay_a;
	logic [1:0]  delay_b;
	logic        random_lat;
	logic        mem_resp_a;
	lc3b_word    mem_rdata_a;
	logic        mem_resp_b;
	lc3b_word    mem_rdata_b;
	logic        mem_read_a;
	lc3b_word    mem_address_a;
	logic        mem_read_b;
	logic        mem_write_b;
	logic [1:0]  mem_wmask_b;
	lc3b_word    mem_address_b;
	lc3b_word    mem_wdata_b;
	logic [31:0] lfsr;
	int          cycles;
	int          errors;
	int          tests;
	int          failed;
	lc3b_word    prog [256];
	lc3b_word    init_dmem [256];
	lc3b_word    exp_addr [$];
	lc3b_word    exp_data [$];

	datapath datapath_i (.*);

	tb_memory memory_i (
		.clk (clk), .arst_n (arst_n), .delay_a (delay_a), .delay_b (delay_b),
		.read_a (mem_read_a), .address_a (mem_address_a),
		.resp_a (mem_resp_a), .rdata_a (mem_rdata_a),
		.read_b (mem_read_b), .write_b (mem_write_b), .wmask_b (mem_wmask_b),
		.address_b (mem_address_b), .wdata_b (mem_wdata_b),
		.resp_b (mem_resp_b), .rdata_b (mem_rdata_b)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	always @(posedge clk) begin
		delay_a <= random_lat ? 2'(rand_bits(2)) : 2'd0;
		delay_b <= random_lat ? 2'(rand_bits(2)) : 2'd0;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles) begin
			$display("timeout: the program did not finish its stores in time");
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before) begin
			failed++;
		end
		$display("%-40s %s", name, (errors == errs_before) ? "ok" : "FAIL");
	endtask

	function automatic lc3b_nzp nzp_of(input lc3b_word v);
		return {v[15], v == 16'h0, !v[15] && v != 16'h0};
	endfunction

	////////////////////////////////////////////////////////////
	// program and ISA model
	////////////////////////////////////////////////////////////

	task automatic build_program();
		logic [2:0] kind;
		logic [2:0] dr;
		int         off;
		for (int i = 0; i < 256; i++) begin
			prog[i] = '0;
			init_dmem[i] = rand_bits(16);
		end
		for (int i = 0; i < n_rand; i++) begin
			kind = 3'(rand_bits(3));
			// r0 stays zero as the base register
			dr = 3'(1 + rand_bits(3) % 7);
			case (kind)
				3'd0: prog[i] = {4'h1, dr, 3'(rand_bits(3)), 3'b000, 3'(rand_bits(3))};
				3'd1: prog[i] = {4'h1, dr, 3'(rand_bits(3)), 1'b1, 5'(rand_bits(5))};
				3'd2: prog[i] = {4'h5, dr, 3'(rand_bits(3)), rand_bits(1) ? 6'(rand_bits(6)) | 6'h20
					: {3'b000, 3'(rand_bits(3))}};
				3'd3: prog[i] = {4'h9, dr, 3'(rand_bits(3)), 6'h3f};
				3'd4: prog[i] = {4'he, dr, 9'(rand_bits(9))};
				3'd5: prog[i] = {4'h6, dr, 3'd0, 1'b0, 5'(rand_bits(5))};
				3'd6: prog[i] = {4'h7, 3'(rand_bits(3)), 3'd0, 1'b0, 5'(rand_bits(5))};
				default: begin
					off = 1 + rand_bits(2);
					if (i + 1 + off > n_rand) begin
						off = n_rand - i - 1;
					end
					prog[i] = {4'h0, 3'(rand_bits(3)), 9'(off)};
				end
			endcase
		end
		// dump every register, then spin in place
		for (int k = 0; k < 8; k++) begin
			prog[n_rand + k] = {4'h7, 3'(k), 3'd0, 6'(24 + k)};
		end
		prog[end_idx] = {4'h0, 3'b111, 9'h1ff};
	endtask

	task automatic run_model();
		lc3b_word r [8];
		lc3b_word m [256];
		lc3b_word ir;
		lc3b_word next;
		lc3b_word b;
		lc3b_word ea;
		lc3b_nzp  cc;
		int       pc_i;
		int       steps;
		r = '{default: '0};
		m = init_dmem;
		cc = 3'b010;
		pc_i = 0;
		steps = 0;
		while (pc_i != end_idx && steps < 1000) begin
			ir = prog[pc_i];
			next = 16'(2 * (pc_i + 1));
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			case (ir[15:12])
				4'h1: r[ir[11:9]] = r[ir[8:6]] + b;
				4'h5: r[ir[11:9]] = r[ir[8:6]] & b;
				4'h9: r[ir[11:9]] = ~r[ir[8:6]];
				4'he: r[ir[11:9]] = next + {{6{ir[8]}}, ir[8:0], 1'b0};
				4'h6: r[ir[11:9]] = m[ea[8:1]];
				4'h7: begin
					exp_addr.push_back(ea);
					exp_data.push_back(r[ir[11:9]]);
					m[ea[8:1]] = r[ir[11:9]];
				end
				default: begin
					if (|(ir[11:9] & cc)) begin
						next = next + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
			endcase
			// lea and str leave the condition codes alone
			if (ir[15:12] inside {4'h1, 4'h5, 4'h9, 4'h6}) begin
				cc = nzp_of(r[ir[11:9]]);
			end
			pc_i = next / 2;
			steps++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// one pass of the program
	////////////////////////////////////////////////////////////

	task automatic run_program(input logic lat, input string label);
		int e0;
		int n;
		int n_exp;
		e0 = errors;
		random_lat = lat;
		@(posedge clk);
		arst_n <= 1'b0;
		memory_i.imem = prog;
		memory_i.dmem = init_dmem;
		memory_i.wr_addr.delete();
		memory_i.wr_data.delete();
		memory_i.wr_mask.delete();
		for (int c = 0; c < 3; c++) begin
			@(negedge clk);
			check_eq("mem_read_b", mem_read_b, 1'b0);
			check_eq("mem_write_b", mem_write_b, 1'b0);
			check_eq("mem_address_a", mem_address_a, pc_reset);
			// first fetch goes out right after reset
			if (c == 2) begin
				check_eq("mem_read_a", mem_read_a, 1'b1);
			end
			@(posedge clk);
			if (c == 1) begin
				arst_n <= 1'b1;
			end
		end
		finish_test({label, " reset"}, e0);
		cycles = 0;
		n_exp = exp_addr.size();
		while (memory_i.wr_addr.size() < n_exp) begin
			@(posedge clk);
		end
		repeat (40) @(posedge clk);
		n = memory_i.wr_addr.size() < n_exp ? memory_i.wr_addr.size() : n_exp;
		e0 = errors;
		for (int k = 0; k < n && k < n_exp - 8; k++) begin
			check_eq("mem_address_b", memory_i.wr_addr[k], exp_addr[k]);
			check_eq("mem_wdata_b", memory_i.wr_data[k], exp_data[k]);
			check_eq("mem_wmask_b", memory_i.wr_mask[k], 2'b11);
		end
		finish_test({label, " ldr/str/br store sequence"}, e0);
		e0 = errors;
		for (int k = n_exp - 8; k < n; k++) begin
			check_eq("dump address", memory_i.wr_addr[k], exp_addr[k]);
			check_eq("dump wdata", memory_i.wr_data[k], exp_data[k]);
			check_eq("dump wmask", memory_i.wr_mask[k], 2'b11);
		end
		finish_test({label, " alu/lea register dump"}, e0);
		e0 = errors;
		check_eq("store count", memory_i.wr_addr.size(), n_exp);
		check_eq("port a address moves", memory_i.moved_a, 0);
		check_eq("port b address moves", memory_i.moved_b, 0);
		finish_test({label, " store count and strobes"}, e0);
	endtask

	initial begin
		arst_n = 1'b0;
		random_lat = 1'b0;
		lfsr = 32'hd00a_4d7d;
		cycles = 0;
		errors = 0;
		tests = 0;
		failed = 0;
		build_program();
		run_model();
		// zero latency first, so dependent pairs meet back to back
		run_program(1'b0, "zero latency");
		run_program(1'b1, "random latency");
		$display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : tb_datapath

/* all.f */
logic/lc3b_pkg.sv
logic/lc3b_regfile.sv
logic/control_rom.sv
logic/hazard_detection.sv
logic/ex_logic.sv
logic/mem_stage.sv
logic/datapath.sv
sim/tb_memory.sv
sim/tb_datapath.sv

/* Bender.yml */
package:
  name: lc3b_pipeline

sources:
  - logic/lc3b_pkg.sv
  - logic/lc3b_regfile.sv
  - logic/control_rom.sv
  - logic/hazard_detection.sv
  - logic/ex_logic.sv
  - logic/mem_stage.sv
  - logic/datapath.sv
  - target: simulation
    files:
      - sim/tb_memory.sv
      - sim/tb_datapath.sv
